//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int word_width = 16;
	localparam int num_regs = 4;

	// address source
	localparam logic addr_pc = 1'b0;
	localparam logic addr_alu_out = 1'b1;

	// register write-back source
	localparam logic [1:0] wb_alu_out = 2'd0;
	localparam logic [1:0] wb_mdr = 2'd1;
	localparam logic [1:0] wb_pc = 2'd2;

	// destination register select
	localparam logic [1:0] dst_rd = 2'd0;
	localparam logic [1:0] dst_rt = 2'd1;
	localparam logic [1:0] dst_r2 = 2'd2;

	// alu operand a and b sources
	localparam logic srca_pc = 1'b0;
	localparam logic srca_rs = 1'b1;
	localparam logic [1:0] srcb_rt = 2'd0;
	localparam logic [1:0] srcb_one = 2'd1;
	localparam logic [1:0] srcb_imm = 2'd2;
	localparam logic [1:0] srcb_zero = 2'd3;

	// next pc source
	localparam logic [1:0] pcsrc_alu = 2'd0;
	localparam logic [1:0] pcsrc_alu_out = 2'd1;
	localparam logic [1:0] pcsrc_jump = 2'd2;
	localparam logic [1:0] pcsrc_rs = 2'd3;

	typedef enum logic [3:0] {
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_bgz = 4'd2,
		op_blz = 4'd3,
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_jal = 4'd10,
		op_rtype = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} funct_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr,
		alu_lhi,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		br_ne,
		br_eq,
		br_gz,
		br_lz
	} branch_t;

	typedef enum logic [2:0] {
		st_fetch_req,
		st_fetch_wait,
		st_decode,
		st_execute,
		st_mem_req,
		st_mem_wait,
		st_writeback,
		st_halted
	} state_t;

	typedef struct packed {
		logic pc_write;
		logic pc_write_cond;
		logic addr_sel;
		logic mem_read;
		logic mem_write;
		logic ir_write;
		logic reg_write;
		logic [1:0] wb_sel;
		logic [1:0] dst_sel;
		logic a_sel;
		logic [1:0] b_sel;
		logic [1:0] pc_src;
		alu_op_t alu_op;
		branch_t branch;
		logic wwd;
		logic new_inst;
	} ctrl_t;

endpackage

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

module register_file (
	input logic clk,
	input logic rst_n,
	input logic [1:0] read1,
	input logic [1:0] read2,
	input logic [1:0] write_reg,
	input logic [cpu_pkg::word_width-1:0] write_data,
	input logic reg_write,
	output logic [cpu_pkg::word_width-1:0] read_out1,
	output logic [cpu_pkg::word_width-1:0] read_out2
);
	import cpu_pkg::*;

	logic [word_width-1:0] regs [num_regs];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

	// reads see the old value during a write cycle
	assign read_out1 = regs[read1];
	assign read_out2 = regs[read2];

	a_write_reg_known: assert property (@(posedge clk) disable iff (!rst_n)
		reg_write |-> !$isunknown(write_reg));

endmodule

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

module alu (
	input logic [cpu_pkg::word_width-1:0] a,
	input logic [cpu_pkg::word_width-1:0] b,
	input cpu_pkg::alu_op_t op,
	input cpu_pkg::branch_t branch,
	output logic [cpu_pkg::word_width-1:0] result,
	output logic bcond
);
	import cpu_pkg::*;

	localparam int msb = word_width - 1;

	logic a_zero;

	assign a_zero = (a == '0);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_not: result = ~a;
			// two's complement of a
			alu_tcp: result = ~a + 1'b1;
			alu_shl: result = {a[msb-1:0], 1'b0};
			// arithmetic shift keeps the sign bit
			alu_shr: result = {a[msb], a[msb:1]};
			alu_lhi: result = {b[7:0], 8'h00};
			alu_pass_b: result = b;
			default: result = b;
		endcase
	end

	// ne and eq compare a with b, gz and lz look at a alone
	always_comb begin
		case (branch)
			br_ne: bcond = (a != b);
			br_eq: bcond = (a == b);
			br_gz: bcond = !a[msb] && !a_zero;
			br_lz: bcond = a[msb];
			default: bcond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`default_nettype none

module control_unit (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::opcode_t opcode,
	input cpu_pkg::funct_t funct,
	output cpu_pkg::ctrl_t ctrl,
	output logic halted
);
	import cpu_pkg::*;

	state_t state;
	state_t state_next;

	logic is_alu_fn;
	logic is_mem;
	logic is_halt;
	logic needs_wb;

	function automatic alu_op_t funct_to_op(input funct_t f);
		case (f)
			fn_add: return alu_add;
			fn_sub: return alu_sub;
			fn_and: return alu_and;
			fn_orr: return alu_or;
			fn_not: return alu_not;
			fn_tcp: return alu_tcp;
			fn_shl: return alu_shl;
			fn_shr: return alu_shr;
			default: return alu_pass_b;
		endcase
	endfunction

	assign is_alu_fn = funct inside {fn_add, fn_sub, fn_and, fn_orr,
		fn_not, fn_tcp, fn_shl, fn_shr};
	assign is_mem = opcode inside {op_lwd, op_swd};
	assign is_halt = (opcode == op_rtype) && (funct == fn_hlt);
	// instructions that spend a writeback cycle after execute
	assign needs_wb = (opcode inside {op_adi, op_ori, op_lhi, op_jal}) ||
		((opcode == op_rtype) && (is_alu_fn || funct == fn_jrl));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_fetch_req;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
			st_fetch_req: state_next = st_fetch_wait;
			st_fetch_wait: state_next = st_decode;
			st_decode: state_next = st_execute;
			st_execute: begin
				if (is_mem) begin
					state_next = st_mem_req;
				end else if (is_halt) begin
					state_next = st_halted;
				end else if (needs_wb) begin
					state_next = st_writeback;
				end else begin
					state_next = st_fetch_req;
				end
			end
			// a store finishes in writeback without a register write
			st_mem_req: state_next = (opcode == op_lwd) ? st_mem_wait : st_writeback;
			st_mem_wait: state_next = st_writeback;
			st_writeback: state_next = st_fetch_req;
			st_halted: state_next = st_halted;
			default: state_next = st_fetch_req;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_pass_b;
		ctrl.b_sel = srcb_zero;
		case (opcode)
			op_beq: ctrl.branch = br_eq;
			op_bgz: ctrl.branch = br_gz;
			op_blz: ctrl.branch = br_lz;
			default: ctrl.branch = br_ne;
		endcase
		case (state)
			st_fetch_req: begin
				// request the instruction and bump pc in the same cycle
				ctrl.addr_sel = addr_pc;
				ctrl.mem_read = 1'b1;
				ctrl.a_sel = srca_pc;
				ctrl.b_sel = srcb_one;
				ctrl.alu_op = alu_add;
				ctrl.pc_src = pcsrc_alu;
				ctrl.pc_write = 1'b1;
			end
			st_fetch_wait: ctrl.ir_write = 1'b1;
			st_decode: begin
				// branch target pc+1+imm lands in the alu output register
				ctrl.a_sel = srca_pc;
				ctrl.b_sel = srcb_imm;
				ctrl.alu_op = alu_add;
			end
			st_execute: begin
				ctrl.a_sel = srca_rs;
				case (opcode)
					op_bne, op_beq, op_bgz, op_blz: begin
						ctrl.b_sel = (opcode inside {op_bgz, op_blz}) ? srcb_zero : srcb_rt;
						ctrl.pc_write_cond = 1'b1;
						ctrl.pc_src = pcsrc_alu_out;
						ctrl.new_inst = 1'b1;
					end
					op_adi, op_lwd, op_swd: begin
						ctrl.b_sel = srcb_imm;
						ctrl.alu_op = alu_add;
					end
					op_ori: begin
						ctrl.b_sel = srcb_imm;
						ctrl.alu_op = alu_or;
					end
					op_lhi: begin
						ctrl.b_sel = srcb_imm;
						ctrl.alu_op = alu_lhi;
					end
					op_jmp: begin
						ctrl.pc_write = 1'b1;
						ctrl.pc_src = pcsrc_jump;
						ctrl.new_inst = 1'b1;
					end
					op_jal: ;
					op_rtype: begin
						if (is_alu_fn) begin
							ctrl.b_sel = srcb_rt;
							ctrl.alu_op = funct_to_op(funct);
						end else if (funct == fn_jpr) begin
							ctrl.pc_write = 1'b1;
							ctrl.pc_src = pcsrc_rs;
							ctrl.new_inst = 1'b1;
						end else if (funct == fn_wwd) begin
							ctrl.wwd = 1'b1;
							ctrl.new_inst = 1'b1;
						end else if (funct != fn_jrl) begin
							ctrl.new_inst = 1'b1;
						end
					end
					default: ctrl.new_inst = 1'b1;
				endcase
			end
			st_mem_req: begin
				ctrl.addr_sel = addr_alu_out;
				ctrl.mem_read = (opcode == op_lwd);
				ctrl.mem_write = (opcode == op_swd);
			end
			st_writeback: begin
				ctrl.new_inst = 1'b1;
				ctrl.reg_write = (opcode != op_swd);
				ctrl.wb_sel = wb_alu_out;
				ctrl.dst_sel = dst_rt;
				if (opcode == op_lwd) begin
					ctrl.wb_sel = wb_mdr;
				end else if (opcode == op_jal || (opcode == op_rtype && funct == fn_jrl)) begin
					// link writes the already incremented pc before the jump lands
					ctrl.wb_sel = wb_pc;
					ctrl.dst_sel = dst_r2;
					ctrl.pc_write = 1'b1;
					ctrl.pc_src = (opcode == op_jal) ? pcsrc_jump : pcsrc_rs;
				end else if (opcode == op_rtype) begin
					ctrl.dst_sel = dst_rd;
				end
			end
			default: ;
		endcase
	end

	assign halted = (state == st_halted);

	a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.mem_read && ctrl.mem_write));

	a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {st_fetch_req, st_fetch_wait, st_decode, st_execute,
			st_mem_req, st_mem_wait, st_writeback, st_halted});

endmodule

`default_nettype wire

//--- hw/cpu.sv
`default_nettype none

module cpu (
	input logic clk,
	input logic rst_n,
	input logic [cpu_pkg::word_width-1:0] data_in,
	output logic read_m,
	output logic write_m,
	output logic [cpu_pkg::word_width-1:0] address,
	output logic [cpu_pkg::word_width-1:0] data_out,
	output logic [cpu_pkg::word_width-1:0] num_inst,
	output logic [cpu_pkg::word_width-1:0] output_port,
	output logic is_halted
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	opcode_t opcode;
	funct_t funct;

	logic [word_width-1:0] pc;
	logic [word_width-1:0] pc_next;
	logic [word_width-1:0] ir;
	logic [word_width-1:0] mdr;
	logic [word_width-1:0] alu_out;

	logic [word_width-1:0] imm_ext;
	logic [word_width-1:0] jump_target;
	logic [word_width-1:0] read_out1;
	logic [word_width-1:0] read_out2;
	logic [word_width-1:0] write_data;
	logic [1:0] write_reg;

	logic [word_width-1:0] alu_a;
	logic [word_width-1:0] alu_b;
	logic [word_width-1:0] alu_result;
	logic bcond;
	logic update_pc;

	assign opcode = opcode_t'(ir[15:12]);
	assign funct = funct_t'(ir[5:0]);

	// ori takes a zero-extended immediate, everything else sign-extends
	assign imm_ext = (opcode == op_ori) ? {8'h00, ir[7:0]} : {{8{ir[7]}}, ir[7:0]};
	// pc already points past the jump here
	assign jump_target = {pc[word_width-1:12], ir[11:0]};

	control_unit i_control_unit (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl),
		.halted(is_halted)
	);

	always_comb begin
		case (ctrl.dst_sel)
			dst_rd: write_reg = ir[7:6];
			dst_rt: write_reg = ir[9:8];
			default: write_reg = 2'd2;
		endcase
		case (ctrl.wb_sel)
			wb_mdr: write_data = mdr;
			wb_pc: write_data = pc;
			default: write_data = alu_out;
		endcase
	end

	register_file i_register_file (
		.clk(clk),
		.rst_n(rst_n),
		.read1(ir[11:10]),
		.read2(ir[9:8]),
		.write_reg(write_reg),
		.write_data(write_data),
		.reg_write(ctrl.reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	assign alu_a = (ctrl.a_sel == srca_pc) ? pc : read_out1;

	always_comb begin
		case (ctrl.b_sel)
			srcb_rt: alu_b = read_out2;
			srcb_one: alu_b = 16'd1;
			srcb_imm: alu_b = imm_ext;
			default: alu_b = '0;
		endcase
	end

	alu i_alu (
		.a(alu_a),
		.b(alu_b),
		.op(ctrl.alu_op),
		.branch(ctrl.branch),
		.result(alu_result),
		.bcond(bcond)
	);

	always_comb begin
		case (ctrl.pc_src)
			pcsrc_alu: pc_next = alu_result;
			pcsrc_alu_out: pc_next = alu_out;
			pcsrc_jump: pc_next = jump_target;
			default: pc_next = read_out1;
		endcase
	end

	assign update_pc = ctrl.pc_write || (ctrl.pc_write_cond && bcond);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (update_pc) begin
			pc <= pc_next;
		end
	end

	// mdr and alu output register simply follow their sources each cycle
	always_ff @(posedge clk) begin
		if (ctrl.ir_write) begin
			ir <= data_in;
		end
		mdr <= data_in;
		alu_out <= alu_result;
	end

	// memory strobes decode straight from the controller state
	// no read request while reset is held
	assign read_m = rst_n && ctrl.mem_read;
	assign write_m = ctrl.mem_write;
	assign address = (ctrl.addr_sel == addr_alu_out) ? alu_out : pc;
	assign data_out = read_out2;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			num_inst <= '0;
			output_port <= '0;
		end else begin
			if (ctrl.new_inst) begin
				num_inst <= num_inst + 1'b1;
			end
			if (ctrl.wwd) begin
				output_port <= read_out1;
			end
		end
	end

	a_read_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		read_m |=> !read_m);

endmodule

`default_nettype wire

//--- tests/isa_model.svh
`ifndef isa_model_svh
`define isa_model_svh

// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic int rand_below(input int n);
	rng_state = xorshift(rng_state);
	return int'(rng_state % n);
endfunction

// random R-type ALU op, destination kept away from the r3 data base
function automatic logic [15:0] alu_word();
	return {4'hf, 2'(rand_below(4)), 2'(rand_below(4)), 2'(rand_below(3)),
		6'(rand_below(8))};
endfunction

task automatic emit(input logic [15:0] word);
	prog[prog_len] = word;
	prog_len++;
endtask

// words that a forward branch or jump may skip over
task automatic emit_fillers(input int count);
	for (int i = 0; i < count; i++) begin
		emit(alu_word());
	end
endtask

task automatic build_program();
	int kind;
	int skip;
	logic [1:0] r;
	for (int a = 0; a < 256; a++) begin
		prog[a] = 16'((a * 40503) ^ 23100);
	end
	prog_len = 0;
	// r3 = 16'hff80, loads and stores land in words 8'h80 and up
	emit({4'd6, 2'd3, 2'd3, 8'h00});
	emit({4'd4, 2'd3, 2'd3, 8'h80});
	while (prog_len < 96) begin
		kind = rand_below(8);
		skip = rand_below(3);
		case (kind)
			2: emit({4'(4 + rand_below(3)), 2'(rand_below(4)), 2'(rand_below(3)),
				8'(rand_below(256))});
			3: begin
				if (rand_below(2) == 0) begin
					emit({4'd7, 2'd3, 2'(rand_below(3)), 8'(rand_below(16))});
				end else begin
					emit({4'd8, 2'd3, 2'(rand_below(4)), 8'(rand_below(16))});
				end
			end
			4: emit({4'hf, 2'(rand_below(4)), 4'd0, 6'd28});
			5: begin
				emit({4'(rand_below(4)), 2'(rand_below(4)), 2'(rand_below(4)), 8'(skip)});
				emit_fillers(skip);
			end
			6: begin
				emit({4'(9 + rand_below(2)), 12'(prog_len + 1 + skip)});
				emit_fillers(skip);
			end
			7: begin
				// lhi clears r, ori loads the target, then jpr or jrl through r
				r = 2'(rand_below(3));
				emit({4'd6, r, r, 8'h00});
				emit({4'd5, r, r, 8'(prog_len + 2 + skip)});
				emit({4'hf, r, 4'd0, (rand_below(2) == 0) ? 6'd25 : 6'd26});
				emit_fillers(skip);
			end
			default: emit(alu_word());
		endcase
	end
	emit(hlt_word);
endtask

// one instruction of the reference ISA on the model state
task automatic step_model();
	logic [15:0] inst;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] r;
	logic [15:0] sext;
	logic [15:0] npc;
	logic [15:0] ea;
	inst = m_mem[m_pc[7:0]];
	a = m_regs[inst[11:10]];
	b = m_regs[inst[9:8]];
	sext = {{8{inst[7]}}, inst[7:0]};
	npc = m_pc + 16'd1;
	ea = a + sext;
	exp_cycles = 4;
	exp_store = 1'b0;
	case (inst[15:12])
		4'd0: if (a != b) npc = npc + sext;
		4'd1: if (a == b) npc = npc + sext;
		4'd2: if (!a[15] && a != 16'd0) npc = npc + sext;
		4'd3: if (a[15]) npc = npc + sext;
		4'd4, 4'd5, 4'd6: begin
			if (inst[15:12] == 4'd4) begin
				m_regs[inst[9:8]] = a + sext;
			end else if (inst[15:12] == 4'd5) begin
				m_regs[inst[9:8]] = a | {8'h00, inst[7:0]};
			end else begin
				m_regs[inst[9:8]] = {inst[7:0], 8'h00};
			end
			exp_cycles = 5;
		end
		4'd7: begin
			m_regs[inst[9:8]] = m_mem[ea[7:0]];
			exp_cycles = 7;
		end
		4'd8: begin
			m_mem[ea[7:0]] = b;
			exp_store = 1'b1;
			exp_write.addr = ea;
			exp_write.data = b;
			exp_cycles = 6;
		end
		4'd9: npc = {npc[15:12], inst[11:0]};
		4'd10: begin
			m_regs[2] = npc;
			npc = {npc[15:12], inst[11:0]};
			exp_cycles = 5;
		end
		4'd15: begin
			if (inst[5:0] < 6'd8) begin
				case (inst[5:0])
					6'd0: r = a + b;
					6'd1: r = a - b;
					6'd2: r = a & b;
					6'd3: r = a | b;
					6'd4: r = ~a;
					6'd5: r = ~a + 16'd1;
					6'd6: r = {a[14:0], 1'b0};
					default: r = {a[15], a[15:1]};
				endcase
				m_regs[inst[7:6]] = r;
				exp_cycles = 5;
			end else if (inst[5:0] == 6'd25) begin
				npc = a;
			end else if (inst[5:0] == 6'd26) begin
				m_regs[2] = npc;
				npc = a;
				exp_cycles = 5;
			end else if (inst[5:0] == 6'd28) begin
				m_port = a;
			end else if (inst[5:0] == 6'd29) begin
				m_halted = 1'b1;
			end
		end
		default: ;
	endcase
	m_pc = npc;
	m_count++;
endtask

`endif

//--- tests/tb_cpu.sv
`default_nettype none

module tb_cpu;

	localparam int timeout_cycles = 4000;
	localparam logic [15:0] hlt_word = 16'hf01d;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
	} mem_write_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [15:0] data_in;
	logic read_m;
	logic write_m;
	logic [15:0] address;
	logic [15:0] data_out;
	logic [15:0] num_inst;
	logic [15:0] output_port;
	logic is_halted;

	logic [31:0] rng_state;
	logic [15:0] prog [256];
	logic [15:0] mem [256];
	logic [15:0] m_mem [256];
	logic [15:0] m_regs [4];
	logic [15:0] m_pc;
	logic [15:0] m_port;
	logic m_halted;
	int m_count;
	int prog_len;
	int exp_cycles;
	logic exp_store;
	mem_write_t exp_write;
	mem_write_t seen_write;
	int seen_writes;
	logic [15:0] fetch_addr;
	logic want_fetch;
	logic [15:0] last_num;
	logic [15:0] halt_count;
	int cycles;
	int errors;
	int waited;
	logic timed_out;

	`include "isa_model.svh"

	cpu i_cpu (
		.clk(clk),
		.rst_n(rst_n),
		.data_in(data_in),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.data_out(data_out),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	always #5 clk = ~clk;

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// word memory, one cycle read latency, low address byte selects the word
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= prog[i];
			end
		end else if (write_m) begin
			mem[address[7:0]] <= data_out;
		end
		if (read_m) begin
			data_in <= mem[address[7:0]];
		end
	end

	// compare one retired instruction with the model
	task automatic retire();
		compare(num_inst, last_num + 16'd1, "num_inst step");
		if (m_halted) begin
			errors++;
			$display("an instruction retired after the program had halted");
		end
		compare(fetch_addr, m_pc, "fetch address");
		step_model();
		compare(cycles - 1, exp_cycles, "instruction cycles");
		compare(output_port, m_port, "output_port");
		compare(seen_writes, exp_store ? 1 : 0, "write_m pulses");
		if (exp_store && seen_writes == 1) begin
			compare(seen_write, exp_write, "store address and data");
		end
		last_num = num_inst;
		cycles = 1;
		seen_writes = 0;
		fetch_addr = 'x;
		want_fetch = 1'b1;
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			cycles++;
			if (num_inst != last_num) begin
				retire();
			end
			// first read of an instruction is its fetch
			if (read_m && want_fetch) begin
				fetch_addr = address;
				want_fetch = 1'b0;
			end
			if (write_m) begin
				seen_write = {address, data_out};
				seen_writes++;
			end
		end
	end

	initial begin
		rst_n <= 1'b0;
		data_in <= '0;
		rng_state = 32'hc390;
		errors = 0;
		cycles = 0;
		seen_writes = 0;
		want_fetch = 1'b1;
		fetch_addr = 'x;
		last_num = '0;
		m_pc = '0;
		m_port = '0;
		m_count = 0;
		m_halted = 1'b0;
		timed_out = 1'b0;
		for (int i = 0; i < 4; i++) begin
			m_regs[i] = '0;
		end
		build_program();
		m_mem = prog;

		repeat (7) @(posedge clk);
		@(negedge clk);
		compare(read_m, 1'b0, "read_m in reset");
		compare(write_m, 1'b0, "write_m in reset");
		compare(is_halted, 1'b0, "is_halted in reset");
		compare(num_inst, 16'd0, "num_inst in reset");
		compare(output_port, 16'd0, "output_port in reset");
		@(posedge clk);
		rst_n <= 1'b1;

		waited = 0;
		while (!is_halted && waited < timeout_cycles) begin
			@(negedge clk);
			waited++;
		end

		if (!is_halted) begin
			timed_out = 1'b1;
			$display("timeout: the processor did not halt within %0d cycles", timeout_cycles);
		end else begin
			// halted core stays quiet
			halt_count = num_inst;
			repeat (20) begin
				@(negedge clk);
				compare(read_m, 1'b0, "read_m after halt");
				compare(num_inst, halt_count, "num_inst after halt");
			end
			compare(m_halted, 1'b1, "model halted");
			compare(num_inst, m_count, "retired instruction count");
		end

		$display("errors: %0d", errors);
		if (errors == 0 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tests
hw/cpu_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/control_unit.sv
hw/cpu.sv
tests/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f sources.f

result=$(./obj_dir/Vtb_cpu)
printf '%s\n' "$result"

printf '%s\n' "$result" | grep -q "STATUS: PASS"
